// File: Makefile
# Verilator build and run of the SRAM test chip testbench
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module sram_test_tb
	./obj_dir/Vsram_test_tb | tee sim.log
	grep -q "Testbench passed" sim.log
	! grep -q "Testbench failed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
+incdir+hdl
hdl/sram_test_pkg.sv
hdl/sram_model.sv
hdl/scan_controller.sv
hdl/sram_test_top.sv
sim/sram_test_properties.sv
sim/sram_test_tb.sv

// File: hdl/scan_controller.sv
`timescale 1ns/1ns
`include "sram_test_defs.svh"

module scan_controller (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             gpio_in,
   input  logic                             gpio_scan,
   input  logic                             gpio_sram_load,
   input  logic                             la_in_load,
   input  logic                             la_sram_load,
   input  sram_test_pkg::cmd_word_t         la_data_in,
   input  logic [`MAX_CHIPS*`DATA_SIZE-1:0] sram_dout0,
   input  logic [`MAX_CHIPS*`DATA_SIZE-1:0] sram_dout1,
   output sram_test_pkg::addr_t             addr0,
   output sram_test_pkg::addr_t             addr1,
   output sram_test_pkg::data_t             din0,
   output sram_test_pkg::data_t             din1,
   output logic                             web0,
   output logic                             web1,
   output sram_test_pkg::wmask_t            wmask0,
   output sram_test_pkg::wmask_t            wmask1,
   output sram_test_pkg::csb_vec_t          csb0,
   output sram_test_pkg::csb_vec_t          csb1,
   output sram_test_pkg::cmd_word_t         la_data_out,
   output logic                             gpio_out
);

   // Field offsets inside one port group, mask at the bottom
   localparam int WEB_BIT  = `WMASK_SIZE;
   localparam int CSB_BIT  = `WMASK_SIZE + 1;
   localparam int DIN_LSB  = `WMASK_SIZE + 2;
   localparam int ADDR_LSB = DIN_LSB + `DATA_SIZE;

   // Port 0 group sits directly above port 1 group
   localparam int P0_LSB  = `PORT_SIZE;
   localparam int SEL_LSB = `TOTAL_SIZE - `SELECT_SIZE;

   sram_test_pkg::cmd_word_t cmd_reg;
   logic [`PORT_SIZE-1:0]    port0_grp;
   logic [`PORT_SIZE-1:0]    port1_grp;
   sram_test_pkg::chip_sel_t chip_select;
   logic                     cmd_csb0;
   logic                     cmd_csb1;
   sram_test_pkg::data_t     read_data0;
   sram_test_pkg::data_t     read_data1;

   // Scan beats parallel load, which beats read capture
   always_ff @(posedge clk) begin
      if (reset) begin
         cmd_reg <= '0;
      end else if (gpio_scan) begin
         cmd_reg <= {cmd_reg[`TOTAL_SIZE-2:0], gpio_in};
      end else if (la_in_load) begin
         cmd_reg <= la_data_in;
      end else if (gpio_sram_load || la_sram_load) begin
         // Only the two din fields take the read data
         cmd_reg[P0_LSB+DIN_LSB +: `DATA_SIZE] <= read_data0;
         cmd_reg[DIN_LSB +: `DATA_SIZE]        <= read_data1;
      end
   end

   assign chip_select = cmd_reg[SEL_LSB +: `SELECT_SIZE];
   assign port0_grp   = cmd_reg[P0_LSB +: `PORT_SIZE];
   assign port1_grp   = cmd_reg[0 +: `PORT_SIZE];

   assign addr0    = port0_grp[ADDR_LSB +: `ADDR_SIZE];
   assign din0     = port0_grp[DIN_LSB +: `DATA_SIZE];
   assign cmd_csb0 = port0_grp[CSB_BIT];
   assign web0     = port0_grp[WEB_BIT];
   assign wmask0   = port0_grp[0 +: `WMASK_SIZE];

   assign addr1    = port1_grp[ADDR_LSB +: `ADDR_SIZE];
   assign din1     = port1_grp[DIN_LSB +: `DATA_SIZE];
   assign cmd_csb1 = port1_grp[CSB_BIT];
   assign web1     = port1_grp[WEB_BIT];
   assign wmask1   = port1_grp[0 +: `WMASK_SIZE];

   // Unselected chips see csb high, the selected one gets the command bit
   assign csb0 = ~({{(`MAX_CHIPS-1){1'b0}}, ~cmd_csb0} << chip_select);
   assign csb1 = ~({{(`MAX_CHIPS-1){1'b0}}, ~cmd_csb1} << chip_select);

   // Read data of the addressed chip, chip-major buses
   always_comb begin
      case (chip_select)
         2'd0: begin
            read_data0 = sram_dout0[0*`DATA_SIZE +: `DATA_SIZE];
            read_data1 = sram_dout1[0*`DATA_SIZE +: `DATA_SIZE];
         end
         2'd1: begin
            read_data0 = sram_dout0[1*`DATA_SIZE +: `DATA_SIZE];
            read_data1 = sram_dout1[1*`DATA_SIZE +: `DATA_SIZE];
         end
         2'd2: begin
            read_data0 = sram_dout0[2*`DATA_SIZE +: `DATA_SIZE];
            read_data1 = sram_dout1[2*`DATA_SIZE +: `DATA_SIZE];
         end
         default: begin
            read_data0 = sram_dout0[3*`DATA_SIZE +: `DATA_SIZE];
            read_data1 = sram_dout1[3*`DATA_SIZE +: `DATA_SIZE];
         end
      endcase
   end

   // MSB goes out first during a scan
   assign gpio_out    = cmd_reg[`TOTAL_SIZE-1];
   assign la_data_out = cmd_reg;

endmodule

// File: hdl/sram_model.sv
`timescale 1ns/1ns
`include "sram_test_defs.svh"

module sram_model (
   input  logic                  clk,
   input  logic                  csb0,
   input  logic                  web0,
   input  sram_test_pkg::wmask_t wmask0,
   input  sram_test_pkg::addr_t  addr0,
   input  sram_test_pkg::data_t  din0,
   output sram_test_pkg::data_t  dout0,
   input  logic                  csb1,
   input  logic                  web1,
   input  sram_test_pkg::wmask_t wmask1,
   input  sram_test_pkg::addr_t  addr1,
   input  sram_test_pkg::data_t  din1,
   output sram_test_pkg::data_t  dout1
);

   // Bits covered by one mask bit
   localparam int BYTE_W = `DATA_SIZE / `WMASK_SIZE;

   sram_test_pkg::data_t mem [`MEM_DEPTH];

   // Masked writes from both ports
   always_ff @(posedge clk) begin
      if (!csb0 && !web0) begin
         for (int b = 0; b < `WMASK_SIZE; b++) begin
            if (wmask0[b]) begin
               mem[addr0][b*BYTE_W +: BYTE_W] <= din0[b*BYTE_W +: BYTE_W];
            end
         end
      end
      // Same-word collision with port 0 is undefined
      if (!csb1 && !web1) begin
         for (int b = 0; b < `WMASK_SIZE; b++) begin
            if (wmask1[b]) begin
               mem[addr1][b*BYTE_W +: BYTE_W] <= din1[b*BYTE_W +: BYTE_W];
            end
         end
      end
   end

   // Registered read data, held while the port is idle or writing
   always_ff @(posedge clk) begin
      if (!csb0 && web0) begin
         dout0 <= mem[addr0];
      end
   end

   always_ff @(posedge clk) begin
      if (!csb1 && web1) begin
         dout1 <= mem[addr1];
      end
   end

endmodule

// File: hdl/sram_test_defs.svh
`ifndef SRAM_TEST_DEFS_SVH
`define SRAM_TEST_DEFS_SVH

// Word address width of one SRAM
`define ADDR_SIZE 4

// Data word width
`define DATA_SIZE 8

// One write-mask bit per 8-bit byte
`define WMASK_SIZE 1

// Number of SRAMs in the bank
`define MAX_CHIPS 4

// Chip-select field width
`define SELECT_SIZE 2

// One port field group: address, data, csb, web and mask
`define PORT_SIZE 15

// Command register width
`define TOTAL_SIZE 32

// Words per SRAM
`define MEM_DEPTH 16

`endif

// File: hdl/sram_test_pkg.sv
`include "sram_test_defs.svh"

package sram_test_pkg;

   // Word address into one SRAM
   typedef logic [`ADDR_SIZE-1:0] addr_t;

   // Data word on either port
   typedef logic [`DATA_SIZE-1:0] data_t;

   typedef logic [`WMASK_SIZE-1:0] wmask_t;

   // Chip-select field of the command word
   typedef logic [`SELECT_SIZE-1:0] chip_sel_t;

   // Active-low select, one bit per chip
   typedef logic [`MAX_CHIPS-1:0] csb_vec_t;

   typedef logic [`TOTAL_SIZE-1:0] cmd_word_t;

endpackage

// File: hdl/sram_test_top.sv
`timescale 1ns/1ns
`include "sram_test_defs.svh"

module sram_test_top (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     gpio_in,
   input  logic                     gpio_scan,
   input  logic                     gpio_sram_load,
   input  logic                     la_in_load,
   input  logic                     la_sram_load,
   input  sram_test_pkg::cmd_word_t la_data_in,
   output sram_test_pkg::cmd_word_t la_data_out,
   output logic                     gpio_out
);

   // Shared port signals, common to every chip
   sram_test_pkg::addr_t     addr0;
   sram_test_pkg::addr_t     addr1;
   sram_test_pkg::data_t     din0;
   sram_test_pkg::data_t     din1;
   logic                     web0;
   logic                     web1;
   sram_test_pkg::wmask_t    wmask0;
   sram_test_pkg::wmask_t    wmask1;
   sram_test_pkg::csb_vec_t  csb0;
   sram_test_pkg::csb_vec_t  csb1;

   // Read data of all chips, chip i in slice i
   logic [`MAX_CHIPS*`DATA_SIZE-1:0] sram_dout0;
   logic [`MAX_CHIPS*`DATA_SIZE-1:0] sram_dout1;

   scan_controller u_ctrl (
      .clk            (clk),
      .reset          (reset),
      .gpio_in        (gpio_in),
      .gpio_scan      (gpio_scan),
      .gpio_sram_load (gpio_sram_load),
      .la_in_load     (la_in_load),
      .la_sram_load   (la_sram_load),
      .la_data_in     (la_data_in),
      .sram_dout0     (sram_dout0),
      .sram_dout1     (sram_dout1),
      .addr0          (addr0),
      .addr1          (addr1),
      .din0           (din0),
      .din1           (din1),
      .web0           (web0),
      .web1           (web1),
      .wmask0         (wmask0),
      .wmask1         (wmask1),
      .csb0           (csb0),
      .csb1           (csb1),
      .la_data_out    (la_data_out),
      .gpio_out       (gpio_out)
   );

   for (genvar i = 0; i < `MAX_CHIPS; i++) begin : g_chip
      sram_model u_sram (
         .clk    (clk),
         .csb0   (csb0[i]),
         .web0   (web0),
         .wmask0 (wmask0),
         .addr0  (addr0),
         .din0   (din0),
         .dout0  (sram_dout0[i*`DATA_SIZE +: `DATA_SIZE]),
         .csb1   (csb1[i]),
         .web1   (web1),
         .wmask1 (wmask1),
         .addr1  (addr1),
         .din1   (din1),
         .dout1  (sram_dout1[i*`DATA_SIZE +: `DATA_SIZE])
      );
   end

endmodule

// File: sim/sram_test_properties.sv
`timescale 1ns/1ns
`include "sram_test_defs.svh"

module sram_test_properties (
   input logic                     clk,
   input logic                     reset,
   input logic                     gpio_scan,
   input sram_test_pkg::csb_vec_t  csb0,
   input sram_test_pkg::csb_vec_t  csb1,
   input sram_test_pkg::cmd_word_t cmd_reg,
   input sram_test_pkg::cmd_word_t la_data_out,
   input logic                     gpio_out
);

   // Command-word positions of the chip select and the two csb bits
   localparam int SEL_LSB  = `TOTAL_SIZE - `SELECT_SIZE;
   localparam int CSB0_BIT = 17;
   localparam int CSB1_BIT = 2;

   sram_test_pkg::chip_sel_t sel;

   assign sel = cmd_reg[SEL_LSB +: `SELECT_SIZE];

   // At most one chip selected on each port, and it is the addressed chip
   a_csb0_one_low: assert property (@(posedge clk) disable iff (reset)
                                    $onehot0(~csb0) && csb0[sel] == cmd_reg[CSB0_BIT])
      else $error("csb0 decode wrong for chip %0d: %b", sel, csb0);

   a_csb1_one_low: assert property (@(posedge clk) disable iff (reset)
                                    $onehot0(~csb1) && csb1[sel] == cmd_reg[CSB1_BIT])
      else $error("csb1 decode wrong for chip %0d: %b", sel, csb1);

   // A shift moves the next register bit onto the scan output
   a_gpio_out_shift: assert property (@(posedge clk) disable iff (reset)
                                      gpio_scan |=> gpio_out == $past(cmd_reg[`TOTAL_SIZE-2]))
      else $error("gpio_out did not take register bit %0d on a shift", `TOTAL_SIZE-2);

   a_reset_clears: assert property (@(posedge clk) reset |=> la_data_out == '0)
      else $error("la_data_out not zero after reset: %h", la_data_out);

endmodule

bind scan_controller sram_test_properties u_props (
   .clk         (clk),
   .reset       (reset),
   .gpio_scan   (gpio_scan),
   .csb0        (csb0),
   .csb1        (csb1),
   .cmd_reg     (cmd_reg),
   .la_data_out (la_data_out),
   .gpio_out    (gpio_out)
);

// File: sim/sram_test_tb.sv
`timescale 1ns/1ns
`include "sram_test_defs.svh"

module sram_test_tb;

   localparam int MAX_OPS      = 64;
   localparam int RESET_CYCLES = 16;
   localparam int SCAN_BITS    = `TOTAL_SIZE;

   // Operation codes in the first column of the vector file
   localparam logic [31:0] OP_LOAD     = 32'h0;
   localparam logic [31:0] OP_LA_CAP   = 32'h1;
   localparam logic [31:0] OP_GPIO_CAP = 32'h2;
   localparam logic [31:0] OP_END      = 32'hF;

   logic                     clk;
   logic                     reset;
   logic                     gpio_in;
   logic                     gpio_scan;
   logic                     gpio_sram_load;
   logic                     la_in_load;
   logic                     la_sram_load;
   sram_test_pkg::cmd_word_t la_data_in;
   sram_test_pkg::cmd_word_t la_data_out;
   logic                     gpio_out;

   // Three words per operation: op code, command, expected la_data_out
   logic [31:0] vec_mem [0:3*MAX_OPS-1];
   int          op_count;
   int          cycle_count = 0;
   int          cycle_limit = 1000;
   logic [31:0] lfsr;

   sram_test_top dut (
      .clk            (clk),
      .reset          (reset),
      .gpio_in        (gpio_in),
      .gpio_scan      (gpio_scan),
      .gpio_sram_load (gpio_sram_load),
      .la_in_load     (la_in_load),
      .la_sram_load   (la_sram_load),
      .la_data_in     (la_data_in),
      .la_data_out    (la_data_out),
      .gpio_out       (gpio_out)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Testbench failed");
         $fatal(1, "Simulation stopped on timeout");
      end
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic feedback;
      feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], feedback};
   endfunction

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
         $display("Testbench failed");
         $fatal(1, "Mismatch in %s", name);
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      assert (actual === expected) else begin
         $display("FAILED %s: expected %b, actual %b", name, expected, actual);
         $display("Testbench failed");
         $fatal(1, "Mismatch in %s", name);
      end
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) @(negedge clk);
   endtask

   task automatic load_word(input logic [31:0] word);
      la_data_in = word;
      la_in_load = 1'b1;
      @(negedge clk);
      la_in_load = 1'b0;
   endtask

   task automatic capture_read(input logic use_gpio);
      if (use_gpio) begin
         gpio_sram_load = 1'b1;
      end else begin
         la_sram_load = 1'b1;
      end
      @(negedge clk);
      gpio_sram_load = 1'b0;
      la_sram_load   = 1'b0;
   endtask

   task automatic count_ops();
      op_count = 0;
      while (op_count < MAX_OPS && vec_mem[3*op_count] != OP_END) begin
         if (vec_mem[3*op_count] != OP_LOAD && vec_mem[3*op_count] != OP_LA_CAP &&
             vec_mem[3*op_count] != OP_GPIO_CAP) begin
            $display("Vector %0d has an unknown operation code", op_count);
            $display("Testbench failed");
            $fatal(1, "Bad vector file");
         end
         op_count++;
      end
      if (op_count == 0 || op_count == MAX_OPS) begin
         $display("The vector file is empty or has no end marker");
         $display("Testbench failed");
         $fatal(1, "Bad vector file");
      end
   endtask

   task automatic run_vector(input int index);
      logic [31:0] op;
      logic [31:0] cmd;
      logic [31:0] expected;
      op       = vec_mem[3*index];
      cmd      = vec_mem[3*index+1];
      expected = vec_mem[3*index+2];
      load_word(cmd);
      idle(2);
      // The strobe lands after the read data is out
      if (op == OP_LA_CAP || op == OP_GPIO_CAP) begin
         capture_read(op == OP_GPIO_CAP);
         idle(1);
      end
      check_word($sformatf("vector %0d", index), expected, la_data_out);
   endtask

   task automatic scan_test();
      logic [31:0] word_in;
      logic [31:0] word_next;
      logic        bit_val;
      word_in = '0;
      for (int i = 0; i < SCAN_BITS; i++) begin
         lfsr    = lfsr_next(lfsr);
         word_in = {word_in[30:0], lfsr[0]};
      end
      // MSB first, with one competing parallel load that must lose
      for (int i = SCAN_BITS - 1; i >= 0; i--) begin
         gpio_scan  = 1'b1;
         gpio_in    = word_in[i];
         la_in_load = (i == 16);
         la_data_in = ~word_in;
         @(negedge clk);
      end
      gpio_scan  = 1'b0;
      gpio_in    = 1'b0;
      la_in_load = 1'b0;
      check_word("scan in", word_in, la_data_out);
      word_next = '0;
      for (int i = SCAN_BITS - 1; i >= 0; i--) begin
         check_bit($sformatf("scan out bit %0d", i), word_in[i], gpio_out);
         lfsr      = lfsr_next(lfsr);
         bit_val   = lfsr[0];
         word_next = {word_next[30:0], bit_val};
         gpio_scan = 1'b1;
         gpio_in   = bit_val;
         @(negedge clk);
      end
      gpio_scan = 1'b0;
      gpio_in   = 1'b0;
      check_word("scan second word", word_next, la_data_out);
   endtask

   initial begin
      clk            = 1'b0;
      reset          = 1'b1;
      gpio_in        = 1'b0;
      gpio_scan      = 1'b0;
      gpio_sram_load = 1'b0;
      la_in_load     = 1'b0;
      la_sram_load   = 1'b0;
      la_data_in     = '0;
      lfsr           = 32'hc8154d0e;
      $readmemh("sim/sram_test_vectors.txt", vec_mem);
      count_ops();
      cycle_limit = op_count * 6 + 2 * SCAN_BITS + RESET_CYCLES + 50;
      idle(RESET_CYCLES);
      reset = 1'b0;
      check_word("reset la_data_out", '0, la_data_out);
      check_bit("reset gpio_out", 1'b0, gpio_out);
      for (int i = 0; i < op_count; i++) begin
         run_vector(i);
      end
      scan_test();
      $display("Testbench passed");
      $finish;
   end

endmodule

// File: sim/sram_test_vectors.txt
// Columns: op code (0 load only, 1 load then LA capture, 2 load then GPIO capture, F end),
// command word, expected la_data_out word
// Plain loads with both ports deselected
0 9E6B5A3E 9E6B5A3E
0 5AFAA5A5 5AFAA5A5
// Chip 1 write, port 0 addr 3 = 5C, port 1 addr 9 = B2
0 4D70CD91 4D70CD91
0 00020004 00020004
// Chip 1 read back on the same ports
1 4C014802 4D714D92
// Chip 1 cross read, port 0 addr 9 and port 1 addr 3
1 64011802 66C91AE2
// Port 1 write with mask clear must leave B2 in addr 9
0 40024A38 40024A38
0 00020004 00020004
1 4C014802 4D714D92
// Addr 6 and addr 12 in every chip with its own data
0 18E8E481 18E8E481
0 00020004 00020004
0 5B14E159 5B14E159
0 00020004 00020004
0 99F8E721 99F8E721
0 00020004 00020004
0 DA04E379 DA04E379
0 00020004 00020004
// Port 0 write with mask clear on chip 2 addr 6
0 9BFC0004 9BFC0004
0 00020004 00020004
// Chip-selected reads of addr 6 and addr 12
1 18016002 18E96482
1 58016002 5B15615A
1 98016002 99F96722
1 D8016002 DA05637A
// Chip 1 again, captured through the GPIO strobe
2 4C014802 4D714D92
F 00000000 00000000
